// File: include/sa_consts.svh
/*
 * systolic array constants
 * grid order and arithmetic widths shared by the package and the RTL
 */
`ifndef SA_CONSTS_SVH
`define SA_CONSTS_SVH

// rows and columns of the grid, also the order of A, B and C
`define SA_N 4

// signed element of A or B
`define SA_DATA_W 8

// holds the sum of SA_N full-scale products
`define SA_PSUM_W 20

`endif

// File: src/sa_pkg.sv
/*
 * sa_pkg
 * vector types and the loader/feeder state encoding
 * for the weight-stationary systolic array
 */
`include "sa_consts.svh"

package sa_pkg;

    typedef logic signed [`SA_DATA_W-1:0] elem_t;
    typedef logic signed [`SA_PSUM_W-1:0] psum_t;

    // element k in lane k, lowest lane first
    typedef logic [`SA_N*`SA_DATA_W-1:0] slice_t;
    typedef logic [`SA_N*`SA_PSUM_W-1:0] crow_t;

    typedef logic [$clog2(`SA_N)-1:0] row_idx_t;

    // B loader and A feeder
    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_wait,
        st_run
    } load_state_t;

endpackage

// File: src/sa_ifs.sv
/*
 * systolic array interfaces
 * sa_weight_if carries B row loads and the job status flags
 * sa_act_if carries the skewed A stream into the grid
 */
`timescale 1ns/10ps
`include "sa_consts.svh"

interface sa_weight_if;
    logic               load_en;
    sa_pkg::row_idx_t   row_sel;
    sa_pkg::slice_t     row_data;
    logic               loaded;
    logic               job_done;

    modport loader (
        output load_en, row_sel, row_data, loaded,
        input  job_done
    );
    modport array (input load_en, row_sel, row_data);
    modport ctl (input loaded, output job_done);
endinterface

interface sa_act_if;
    logic [`SA_N-1:0]           act_valid;
    sa_pkg::elem_t [`SA_N-1:0]  act_data;
    logic                       start;

    modport feeder (output act_valid, act_data, start);
    modport array (input act_valid, act_data, start);
endinterface

// File: src/sa_pe.sv
/*
 * systolic processing element
 * holds one weight of B, adds act * weight to the partial sum
 * from above and forwards the activation to the right
 */
`timescale 1ns/10ps
`include "sa_consts.svh"

module sa_pe (
    input  logic            s_clk,
    input  logic            s_rst,
    input  logic            w_load,
    input  sa_pkg::elem_t   w_in,
    input  logic            act_valid_in,
    input  sa_pkg::elem_t   act_in,
    input  sa_pkg::psum_t   psum_in,
    output logic            act_valid_out,
    output sa_pkg::elem_t   act_out,
    output sa_pkg::psum_t   psum_out
);

    sa_pkg::elem_t                   weight;
    logic signed [2*`SA_DATA_W-1:0]  prod;

    assign prod = act_in * weight;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            act_valid_out <= 1'b0;
        end else begin
            act_valid_out <= act_valid_in;
        end
    end

    always_ff @(posedge s_clk) begin
        if (w_load) begin
            weight <= w_in;
        end
        act_out  <= act_in;
        psum_out <= psum_in + sa_pkg::psum_t'(prod);
    end

endmodule

// File: src/sa_pe_array.sv
/*
 * SA_N x SA_N processing element grid
 * activations move right along each row, partial sums move down
 * each column; B row r is held by grid row r
 */
`timescale 1ns/10ps
`include "sa_consts.svh"

module sa_pe_array (
    input  logic                        s_clk,
    input  logic                        s_rst,
    sa_weight_if.array                  wgt,
    sa_act_if.array                     act,
    output logic [`SA_N-1:0]            bot_valid,
    output sa_pkg::psum_t [`SA_N-1:0]   bot_psum
);

    logic [`SA_N-1:0]   row_load;
    logic [`SA_N-1:0]   v_out [`SA_N];
    sa_pkg::elem_t      a_out [`SA_N][`SA_N];
    sa_pkg::psum_t      p_out [`SA_N][`SA_N];

    for (genvar r = 0; r < `SA_N; r++) begin : g_row
        assign row_load[r] = wgt.load_en && (wgt.row_sel == sa_pkg::row_idx_t'(r));

        for (genvar c = 0; c < `SA_N; c++) begin : g_col
            logic          v_in;
            sa_pkg::elem_t a_in;
            sa_pkg::psum_t p_in;

            if (c == 0) begin : g_edge
                assign v_in = act.act_valid[r];
                assign a_in = act.act_data[r];
            end else begin : g_chain
                assign v_in = v_out[r][c-1];
                assign a_in = a_out[r][c-1];
            end

            if (r == 0) begin : g_top
                assign p_in = '0;
            end else begin : g_down
                assign p_in = p_out[r-1][c];
            end

            sa_pe u_pe (
                .s_clk         (s_clk),
                .s_rst         (s_rst),
                .w_load        (row_load[r]),
                .w_in          (wgt.row_data[c*`SA_DATA_W +: `SA_DATA_W]),
                .act_valid_in  (v_in),
                .act_in        (a_in),
                .psum_in       (p_in),
                .act_valid_out (v_out[r][c]),
                .act_out       (a_out[r][c]),
                .psum_out      (p_out[r][c])
            );
        end
    end

    // column c is valid when the bottom row has seen its activation
    for (genvar c = 0; c < `SA_N; c++) begin : g_bot
        assign bot_valid[c] = v_out[`SA_N-1][c];
        assign bot_psum[c]  = p_out[`SA_N-1][c];
    end

endmodule

// File: src/sa_weight_loader.sv
/*
 * B weight loader
 * accepts B as SA_N row slices and writes one row of weights
 * into the grid per accepted slice, then holds loaded until
 * the result collector closes the job
 */
`timescale 1ns/10ps
`include "sa_consts.svh"

module sa_weight_loader (
    input  logic            s_clk,
    input  logic            s_rst,
    input  logic            b_slice_valid,
    input  sa_pkg::slice_t  b_slice_data,
    input  logic            b_slice_done,
    output logic            b_slice_ready,
    sa_weight_if.loader     wgt
);

    sa_pkg::load_state_t state;
    sa_pkg::row_idx_t    row_cnt;
    logic                b_fire;

    assign b_fire = b_slice_valid & b_slice_ready;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state         <= sa_pkg::st_idle;
            b_slice_ready <= 1'b0;
            row_cnt       <= '0;
            wgt.load_en   <= 1'b0;
            wgt.loaded    <= 1'b0;
        end else begin
            wgt.load_en <= b_fire;
            case (state)
                sa_pkg::st_idle: begin
                    state         <= sa_pkg::st_load;
                    b_slice_ready <= 1'b1;
                end
                sa_pkg::st_load: begin
                    if (b_fire) begin
                        row_cnt <= row_cnt + 1'b1;
                        if (b_slice_done) begin
                            state         <= sa_pkg::st_wait;
                            b_slice_ready <= 1'b0;
                        end
                    end
                end
                sa_pkg::st_wait: begin
                    // last row lands in the grid on this edge
                    state      <= sa_pkg::st_run;
                    wgt.loaded <= 1'b1;
                end
                default: begin
                    if (wgt.job_done) begin
                        state         <= sa_pkg::st_load;
                        b_slice_ready <= 1'b1;
                        row_cnt       <= '0;
                        wgt.loaded    <= 1'b0;
                    end
                end
            endcase
        end
    end

    // row select and weights travel with load_en
    always_ff @(posedge s_clk) begin
        if (b_fire) begin
            wgt.row_sel  <= row_cnt;
            wgt.row_data <= b_slice_data;
        end
    end

endmodule

// File: src/sa_act_feeder.sv
/*
 * A activation feeder
 * buffers the SA_N row slices of A, waits for the weights,
 * then streams A into the grid rows with one cycle of skew per row
 */
`timescale 1ns/10ps
`include "sa_consts.svh"

module sa_act_feeder (
    input  logic            s_clk,
    input  logic            s_rst,
    input  logic            a_slice_valid,
    input  sa_pkg::slice_t  a_slice_data,
    input  logic            a_slice_done,
    output logic            a_slice_ready,
    sa_weight_if.ctl        wgt,
    sa_act_if.feeder        act
);

    localparam int STREAM_LEN = 2 * `SA_N - 1;
    localparam int CNT_W      = $clog2(2 * `SA_N);

    sa_pkg::load_state_t state;
    sa_pkg::row_idx_t    a_cnt;
    logic [CNT_W-1:0]    s_cnt;
    sa_pkg::slice_t      a_buf [`SA_N];
    logic                a_fire;
    logic                streaming;

    assign a_fire    = a_slice_valid & a_slice_ready;
    assign streaming = (state == sa_pkg::st_run) && (s_cnt < CNT_W'(STREAM_LEN));

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state         <= sa_pkg::st_idle;
            a_slice_ready <= 1'b0;
            a_cnt         <= '0;
            s_cnt         <= '0;
            act.start     <= 1'b0;
        end else begin
            act.start <= 1'b0;
            case (state)
                sa_pkg::st_idle: begin
                    state         <= sa_pkg::st_load;
                    a_slice_ready <= 1'b1;
                end
                sa_pkg::st_load: begin
                    if (a_fire) begin
                        a_cnt <= a_cnt + 1'b1;
                        if (a_slice_done) begin
                            state         <= sa_pkg::st_wait;
                            a_slice_ready <= 1'b0;
                        end
                    end
                end
                sa_pkg::st_wait: begin
                    if (wgt.loaded) begin
                        state     <= sa_pkg::st_run;
                        s_cnt     <= '0;
                        act.start <= 1'b1;
                    end
                end
                default: begin
                    // stream runs out, then hold until the results are out
                    if (streaming) begin
                        s_cnt <= s_cnt + 1'b1;
                    end
                    if (wgt.job_done) begin
                        state         <= sa_pkg::st_load;
                        a_slice_ready <= 1'b1;
                        a_cnt         <= '0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge s_clk) begin
        if (a_fire) begin
            a_buf[a_cnt] <= a_slice_data;
        end
    end

    // grid row r carries A[s_cnt - r][r]
    for (genvar r = 0; r < `SA_N; r++) begin : g_row
        logic             in_win;
        sa_pkg::row_idx_t a_idx;

        assign a_idx  = sa_pkg::row_idx_t'(s_cnt - CNT_W'(r));
        assign in_win = streaming && (s_cnt >= CNT_W'(r)) && (s_cnt < CNT_W'(r + `SA_N));

        assign act.act_valid[r] = in_win;
        assign act.act_data[r]  = in_win ? a_buf[a_idx][r*`SA_DATA_W +: `SA_DATA_W] : '0;
    end

endmodule

// File: src/sa_result_collector.sv
/*
 * result collector
 * delays bottom column c by SA_N-1-c cycles so every row of C
 * leaves in one cycle, then marks the last row and ends the job
 */
`timescale 1ns/10ps
`include "sa_consts.svh"

module sa_result_collector (
    input  logic                        s_clk,
    input  logic                        s_rst,
    input  logic [`SA_N-1:0]            bot_valid,
    input  sa_pkg::psum_t [`SA_N-1:0]   bot_psum,
    sa_weight_if.ctl                    wgt,
    output logic                        c_valid,
    output sa_pkg::crow_t               c_data,
    output logic                        c_last
);

    logic [`SA_N-1:0]           al_valid;
    sa_pkg::psum_t [`SA_N-1:0]  al_psum;
    sa_pkg::row_idx_t           row_cnt;
    logic                       row_out;

    for (genvar c = 0; c < `SA_N; c++) begin : g_col
        localparam int DEPTH = `SA_N - 1 - c;

        if (DEPTH == 0) begin : g_direct
            assign al_valid[c] = bot_valid[c];
            assign al_psum[c]  = bot_psum[c];
        end else begin : g_delay
            logic [DEPTH-1:0] v_sr;
            sa_pkg::psum_t    p_sr [DEPTH];

            always_ff @(posedge s_clk or posedge s_rst) begin
                if (s_rst) begin
                    v_sr <= '0;
                end else begin
                    v_sr[0] <= bot_valid[c];
                    for (int k = 1; k < DEPTH; k++) begin
                        v_sr[k] <= v_sr[k-1];
                    end
                end
            end

            always_ff @(posedge s_clk) begin
                p_sr[0] <= bot_psum[c];
                for (int k = 1; k < DEPTH; k++) begin
                    p_sr[k] <= p_sr[k-1];
                end
            end

            assign al_valid[c] = v_sr[DEPTH-1];
            assign al_psum[c]  = p_sr[DEPTH-1];
        end
    end

    assign row_out = &al_valid;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            c_valid <= 1'b0;
            c_last  <= 1'b0;
            row_cnt <= '0;
        end else begin
            c_valid <= row_out;
            c_last  <= row_out && (row_cnt == sa_pkg::row_idx_t'(`SA_N - 1));
            if (row_out) begin
                row_cnt <= (row_cnt == sa_pkg::row_idx_t'(`SA_N - 1)) ? '0 : row_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (row_out) begin
            c_data <= al_psum;
        end
    end

    // job ends with the last row of C
    assign wgt.job_done = c_last;

endmodule

// File: src/sa_top.sv
/*
 * weight-stationary systolic array, C = A x B
 * B is loaded into the grid row by row, A is buffered and streamed
 * with skew, and C leaves one row per cycle
 */
`timescale 1ns/10ps
`include "sa_consts.svh"

module sa_top (
    input  logic            s_clk,
    input  logic            s_rst,

    input  logic            a_slice_valid,
    input  sa_pkg::slice_t  a_slice_data,
    input  logic            a_slice_done,
    output logic            a_slice_ready,

    input  logic            b_slice_valid,
    input  sa_pkg::slice_t  b_slice_data,
    input  logic            b_slice_done,
    output logic            b_slice_ready,

    output logic            c_valid,
    output sa_pkg::crow_t   c_data,
    output logic            c_last
);

    sa_weight_if u_wgt_if ();
    sa_act_if    u_act_if ();

    logic [`SA_N-1:0]           bot_valid;
    sa_pkg::psum_t [`SA_N-1:0]  bot_psum;

    sa_weight_loader u_weight_loader (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .b_slice_valid (b_slice_valid),
        .b_slice_data  (b_slice_data),
        .b_slice_done  (b_slice_done),
        .b_slice_ready (b_slice_ready),
        .wgt           (u_wgt_if.loader)
    );

    sa_act_feeder u_act_feeder (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .a_slice_valid (a_slice_valid),
        .a_slice_data  (a_slice_data),
        .a_slice_done  (a_slice_done),
        .a_slice_ready (a_slice_ready),
        .wgt           (u_wgt_if.ctl),
        .act           (u_act_if.feeder)
    );

    sa_pe_array u_pe_array (
        .s_clk     (s_clk),
        .s_rst     (s_rst),
        .wgt       (u_wgt_if.array),
        .act       (u_act_if.array),
        .bot_valid (bot_valid),
        .bot_psum  (bot_psum)
    );

    sa_result_collector u_result_collector (
        .s_clk     (s_clk),
        .s_rst     (s_rst),
        .bot_valid (bot_valid),
        .bot_psum  (bot_psum),
        .wgt       (u_wgt_if.ctl),
        .c_valid   (c_valid),
        .c_data    (c_data),
        .c_last    (c_last)
    );

endmodule

// File: dv/tb_sa_top.sv
/*
 * testbench for the systolic array top level
 * sends A and B as row slices, checks every row of C against a
 * reference dot product, and watches the ready, valid and last timing
 */
`timescale 1ns/10ps
`include "sa_consts.svh"

module tb_sa_top;

    localparam int N       = `SA_N;
    localparam int DW      = `SA_DATA_W;
    localparam int PW      = `SA_PSUM_W;
    localparam int TIMEOUT = 300;

    logic           s_clk;
    logic           s_rst;
    logic           a_slice_valid;
    sa_pkg::slice_t a_slice_data;
    logic           a_slice_done;
    logic           a_slice_ready;
    logic           b_slice_valid;
    sa_pkg::slice_t b_slice_data;
    logic           b_slice_done;
    logic           b_slice_ready;
    logic           c_valid;
    sa_pkg::crow_t  c_data;
    logic           c_last;

    int mat_a [N][N];
    int mat_b [N][N];
    int seed;
    int check_cnt;
    int err_cnt;
    int err_base;
    int hung;
    int jobs_done;
    int out_row;
    bit expect_job;
    bit a_closed;
    bit b_closed;
    bit prev_valid;

    sa_top u_dut (
        .s_clk         (s_clk),
        .s_rst         (s_rst),
        .a_slice_valid (a_slice_valid),
        .a_slice_data  (a_slice_data),
        .a_slice_done  (a_slice_done),
        .a_slice_ready (a_slice_ready),
        .b_slice_valid (b_slice_valid),
        .b_slice_data  (b_slice_data),
        .b_slice_done  (b_slice_done),
        .b_slice_ready (b_slice_ready),
        .c_valid       (c_valid),
        .c_data        (c_data),
        .c_last        (c_last)
    );

    always #5 s_clk = ~s_clk;

    // C[i][j] as a plain signed sum of products
    function automatic longint ref_dot(input int i, input int j);
        longint acc;
        acc = 0;
        for (int k = 0; k < N; k++) begin
            acc += longint'(mat_a[i][k]) * longint'(mat_b[k][j]);
        end
        return acc;
    endfunction

    function automatic sa_pkg::slice_t pack_row(input bit is_b, input int r);
        sa_pkg::slice_t s;
        for (int k = 0; k < N; k++) begin
            s[k*DW +: DW] = is_b ? DW'(mat_b[r][k]) : DW'(mat_a[r][k]);
        end
        return s;
    endfunction

    task automatic compare_value(input string what, input logic signed [63:0] got,
                                 input logic signed [63:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %0t: %s, got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // mode 0 random, 1 identity B, 2 and 3 full-scale corners
    task automatic fill_mats(input int mode);
        int v;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                v = $random(seed);
                mat_a[i][j] = (v & 255) - 128;
                v = $random(seed);
                mat_b[i][j] = (v & 255) - 128;
                if (mode == 1) begin
                    mat_b[i][j] = (i == j) ? 1 : 0;
                end else if (mode == 2) begin
                    mat_a[i][j] = -128;
                    mat_b[i][j] = -128;
                end else if (mode == 3) begin
                    mat_a[i][j] = 127;
                    mat_b[i][j] = -128;
                end
            end
        end
    endtask

    task automatic send_matrix(input bit is_b, input int gap_max);
        int gap;
        int t;
        bit hs;
        for (int r = 0; r < N && hung == 0; r++) begin
            gap = (gap_max > 0) ? (r + 2 * int'(is_b)) % (gap_max + 1) : 0;
            repeat (gap) begin
                @(posedge s_clk);
                #1;
            end
            if (is_b) begin
                b_slice_valid = 1'b1;
                b_slice_data  = pack_row(1'b1, r);
                b_slice_done  = (r == N - 1);
            end else begin
                a_slice_valid = 1'b1;
                a_slice_data  = pack_row(1'b0, r);
                a_slice_done  = (r == N - 1);
            end
            hs = 1'b0;
            // ready is sampled mid-cycle, the transfer happens on the next edge
            for (t = 0; t < TIMEOUT && !hs; t++) begin
                @(negedge s_clk);
                hs = is_b ? b_slice_ready : a_slice_ready;
                @(posedge s_clk);
                #1;
            end
            if (is_b) begin
                b_slice_valid = 1'b0;
                b_slice_done  = 1'b0;
            end else begin
                a_slice_valid = 1'b0;
                a_slice_done  = 1'b0;
            end
            if (!hs) begin
                $display("timeout: %s slice %0d was never accepted", is_b ? "B" : "A", r);
                hung++;
            end
        end
        if (hung == 0) begin
            if (is_b) begin
                b_closed = 1'b1;
            end else begin
                a_closed = 1'b1;
            end
        end
    endtask

    // order 0 sends both at once, 1 sends A first, 2 sends B first
    task automatic run_job(input int order, input int gap_max);
        int t;
        int target;
        if (hung != 0) begin
            return;
        end
        target = jobs_done + 1;
        if (order == 0) begin
            fork
                send_matrix(1'b0, gap_max);
                send_matrix(1'b1, gap_max);
            join
        end else if (order == 1) begin
            send_matrix(1'b0, gap_max);
            send_matrix(1'b1, gap_max);
        end else begin
            send_matrix(1'b1, gap_max);
            send_matrix(1'b0, gap_max);
        end
        if (hung == 0) begin
            expect_job = 1'b1;
            for (t = 0; t < TIMEOUT && jobs_done < target; t++) begin
                @(posedge s_clk);
            end
            if (jobs_done < target) begin
                $display("timeout: job %0d never returned its last row of C", target);
                hung++;
            end
            #1;
        end
    endtask

    task automatic report_test(input int num, input string name);
        if (err_cnt == err_base && hung == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors, %0d timeouts", num, name,
                     err_cnt - err_base, hung);
        end
        err_base = err_cnt;
    endtask

    // checks the rows of C and the handshake state
    always @(negedge s_clk) begin
        if (a_closed) begin
            compare_value("a_slice_ready high between done and c_last", a_slice_ready, 0);
        end
        if (b_closed) begin
            compare_value("b_slice_ready high between done and c_last", b_slice_ready, 0);
        end
        if (c_valid) begin
            if (!expect_job) begin
                compare_value("c_valid with no job loaded", c_valid, 0);
            end else begin
                for (int j = 0; j < N; j++) begin
                    compare_value($sformatf("C[%0d][%0d]", out_row, j),
                                  $signed(c_data[j*PW +: PW]), ref_dot(out_row, j));
                end
                compare_value($sformatf("c_last on row %0d", out_row), c_last,
                              out_row == N - 1);
                if (out_row != 0) begin
                    compare_value("c_valid gap inside a job", prev_valid, 1);
                end
                if (out_row == N - 1) begin
                    out_row    = 0;
                    jobs_done++;
                    expect_job = 1'b0;
                    a_closed   = 1'b0;
                    b_closed   = 1'b0;
                end else begin
                    out_row++;
                end
            end
        end else begin
            compare_value("c_last without c_valid", c_last, 0);
        end
        prev_valid = c_valid;
    end

    initial begin
        s_clk         = 1'b0;
        s_rst         = 1'b1;
        a_slice_valid = 1'b0;
        a_slice_data  = '0;
        a_slice_done  = 1'b0;
        b_slice_valid = 1'b0;
        b_slice_data  = '0;
        b_slice_done  = 1'b0;
        seed          = 28;
        check_cnt     = 0;
        err_cnt       = 0;
        err_base      = 0;
        hung          = 0;
        jobs_done     = 0;
        out_row       = 0;
        expect_job    = 1'b0;
        a_closed      = 1'b0;
        b_closed      = 1'b0;
        prev_valid    = 1'b0;

        for (int i = 0; i < 16; i++) begin
            @(negedge s_clk);
            compare_value("a_slice_ready in reset", a_slice_ready, 0);
            compare_value("b_slice_ready in reset", b_slice_ready, 0);
            compare_value("c_valid in reset", c_valid, 0);
        end
        @(posedge s_clk);
        #1;
        s_rst = 1'b0;
        @(posedge s_clk);
        @(negedge s_clk);
        compare_value("a_slice_ready after reset", a_slice_ready, 1);
        compare_value("b_slice_ready after reset", b_slice_ready, 1);
        @(posedge s_clk);
        #1;
        report_test(1, "reset and ready");

        fill_mats(1);
        run_job(0, 0);
        report_test(2, "identity B");

        fill_mats(0);
        run_job(0, 0);
        fill_mats(0);
        run_job(0, 1);
        report_test(3, "random signed A and B");

        fill_mats(2);
        run_job(0, 0);
        fill_mats(3);
        run_job(0, 0);
        report_test(4, "full-scale values");

        fill_mats(0);
        run_job(1, 2);
        fill_mats(0);
        run_job(2, 2);
        fill_mats(0);
        run_job(0, 3);
        report_test(5, "slice order and gaps");

        $display("checks %0d, errors %0d, timeouts %0d, jobs %0d",
                 check_cnt, err_cnt, hung, jobs_done);
        if (err_cnt == 0 && hung == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+include
src/sa_pkg.sv
src/sa_ifs.sv
src/sa_pe.sv
src/sa_pe_array.sv
src/sa_weight_loader.sv
src/sa_act_feeder.sv
src/sa_result_collector.sv
src/sa_top.sv
dv/tb_sa_top.sv

// File: run_sim.sh
#!/bin/sh
# build the systolic array testbench with Verilator, run it, and
# decide pass or fail from the simulation log
rm -f sim.log \
    && verilator --binary --timing -Wno-fatal --timescale 1ns/10ps \
        --top-module tb_sa_top -f sim.f -o tb_sa_top_sim > build.log 2>&1 \
    && ./obj_dir/tb_sa_top_sim > sim.log 2>&1 \
    && grep -q "Simulation PASSED" sim.log \
    && echo "run passed" \
    || { echo "run failed, see build.log and sim.log"; exit 1; }
